// ==== logic/trojan_params.svh ====
/* Trojan memory host shared constants
   Memory geometry, key and LFSR seeds and the LFSR feedback mask */

`ifndef TROJAN_PARAMS_SVH
`define TROJAN_PARAMS_SVH

// Memory geometry
// The key mixing XORs the address into one key byte, so this stays at 8
`define TROJAN_ADDR_WIDTH 8
`define TROJAN_DATA_WIDTH 16

// Key register value after reset
`define TROJAN_KEY_SEED 128'hFEDC_BA98_7654_3210_FEDC_BA98_7654_3210

// Nonzero LFSR state after reset
`define TROJAN_LFSR_SEED 64'hACE1_2468_1357_BDF0

// Galois feedback mask for a right shift
// Taps at 64, 63, 61 and 60 give a maximal length sequence
`define TROJAN_LFSR_TAPS 64'hD800_0000_0000_0000

`endif

// ==== logic/trojan_pkg.sv ====
/* Trojan memory host types
   Request and response words and the two views of the key register */

`include "trojan_params.svh"

package trojan_pkg;

    // One access request sampled at the rising clock edge
    // Write wins when both strobes are high
    typedef struct packed {
        logic                          wr;
        logic                          rd;
        logic [`TROJAN_ADDR_WIDTH-1:0] addr;
        logic [`TROJAN_DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    // Response that is valid for one cycle after every access
    typedef struct packed {
        logic [`TROJAN_DATA_WIDTH-1:0] rdata;
        logic                          valid;
    } mem_rsp_t;

    // Key split into its upper and lower 64 bits
    typedef struct packed {
        logic [63:0] hi;
        logic [63:0] lo;
    } key_halves_t;

    // Same 128 key bits seen two ways
    // flat for the byte rotation, halves for the payload fold
    typedef union packed {
        logic [127:0] flat;
        key_halves_t  halves;
    } key_word_u;

endpackage

// ==== logic/key_schedule.sv ====
/* Key schedule
   Rotates the 128-bit key up one byte per access and mixes in the address */

`timescale 1ns/10ps

`include "trojan_params.svh"

module key_schedule (
    input  logic                 clk,
    input  logic                 rst,
    input  trojan_pkg::mem_req_t req,
    output trojan_pkg::key_word_u key
);

    trojan_pkg::key_word_u key_q;
    trojan_pkg::key_word_u key_next;
    logic                  access;
    logic [7:0]            mix_byte;

    // Either strobe counts as an access
    assign access = req.wr | req.rd;

    // Old top byte wraps around to the bottom and takes in the address
    assign mix_byte = key_q.flat[127:120] ^ req.addr;

    always_comb begin
        key_next.flat = {key_q.flat[119:0], mix_byte};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q.flat <= `TROJAN_KEY_SEED;
        end else if (access) begin
            key_q <= key_next;
        end
    end

    // Key holds on idle cycles
    assign key = key_q;

endmodule

// ==== logic/trojan_payload.sv ====
/* Trojan payload generator
   Free-running Galois LFSR folded with both key halves into a 64-bit load */

`timescale 1ns/10ps

`include "trojan_params.svh"

module trojan_payload (
    input  logic                  clk,
    input  logic                  rst,
    input  trojan_pkg::key_word_u key,
    output logic [63:0]           load
);

    logic [63:0] lfsr_q;
    logic [63:0] lfsr_shifted;
    logic [63:0] lfsr_feedback;
    logic [63:0] lfsr_next;
    logic [63:0] key_fold;

    // Galois step shifts right and applies the tap mask when a one falls out
    assign lfsr_shifted = {1'b0, lfsr_q[63:1]};

    always_comb begin
        if (lfsr_q[0]) begin
            lfsr_feedback = `TROJAN_LFSR_TAPS;
        end else begin
            lfsr_feedback = '0;
        end
    end

    assign lfsr_next = lfsr_shifted ^ lfsr_feedback;

    // Advances every cycle regardless of memory traffic
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= `TROJAN_LFSR_SEED;
        end else begin
            lfsr_q <= lfsr_next;
        end
    end

    // Both halves collapse into one word
    assign key_fold = key.halves.hi ^ key.halves.lo;

    // Combinational from the current state, so it changes every cycle
    // even while the key holds
    assign load = lfsr_q ^ key_fold;

endmodule

// ==== logic/scrambled_memory.sv ====
/* Scrambled memory
   256 x 16 array whose writes are XORed with the payload, registered reads */

`timescale 1ns/10ps

`include "trojan_params.svh"

module scrambled_memory (
    input  logic                 clk,
    input  logic                 rst,
    input  trojan_pkg::mem_req_t req,
    input  logic [63:0]          load,
    output trojan_pkg::mem_rsp_t rsp
);

    localparam int DEPTH = 1 << `TROJAN_ADDR_WIDTH;

    logic [`TROJAN_DATA_WIDTH-1:0] mem [DEPTH];

    logic                          wr_en;
    logic                          rd_en;
    logic                          access;
    logic [`TROJAN_DATA_WIDTH-1:0] wr_word;
    logic [`TROJAN_DATA_WIDTH-1:0] rdata_q;
    logic                          valid_q;

    // Write takes priority so a combined request never reads
    assign wr_en  = req.wr;
    assign rd_en  = req.rd & ~req.wr;
    assign access = req.wr | req.rd;

    // Only the low payload bits reach the array
    assign wr_word = req.wdata ^ load[`TROJAN_DATA_WIDTH-1:0];

    // Scrambled word lands in the array at the write edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[req.addr] <= wr_word;
        end
    end

    // Read data holds between reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (rd_en) begin
            rdata_q <= mem[req.addr];
        end
    end

    // One pulse per access of either kind
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= access;
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.valid = valid_q;

endmodule

// ==== logic/trojan_memory_host.sv ====
/* Trojan memory host top level
   Key schedule and payload generator corrupting the memory write path */

`timescale 1ns/10ps

module trojan_memory_host (
    input  logic                 clk,
    input  logic                 rst,
    input  trojan_pkg::mem_req_t req,
    output trojan_pkg::mem_rsp_t rsp
);

    trojan_pkg::key_word_u key;
    logic [63:0]           load;

    // Key moves only on accesses
    key_schedule u_key_schedule (
        .clk (clk),
        .rst (rst),
        .req (req),
        .key (key)
    );

    // Trojan body forming the payload word from the LFSR and the key
    trojan_payload u_trojan_payload (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .load (load)
    );

    // Host memory whose writes are scrambled by the payload
    scrambled_memory u_scrambled_memory (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .load (load),
        .rsp  (rsp)
    );

endmodule

// ==== tests/trojan_memory_host_assert.sv ====
/* Trojan memory host assertions
   Valid pulse timing and read data stability, bound to the top level */

`timescale 1ns/10ps

module trojan_memory_host_assert (
    input logic                 clk,
    input logic                 rst,
    input trojan_pkg::mem_req_t req,
    input trojan_pkg::mem_rsp_t rsp
);

    // Every access is answered one cycle later
    valid_after_access: assert property (
        @(posedge clk) disable iff (rst)
        (req.wr || req.rd) |=> rsp.valid
    ) else $error("valid missing one cycle after an access");

    // No pulse without an access the cycle before
    no_valid_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        !(req.wr || req.rd) |=> !rsp.valid
    ) else $error("valid high without a preceding access");

    // Read data only moves after a read that is not also a write
    rdata_holds: assert property (
        @(posedge clk) disable iff (rst)
        !(req.rd && !req.wr) |=> $stable(rsp.rdata)
    ) else $error("read data changed without a preceding read");

endmodule

bind trojan_memory_host trojan_memory_host_assert u_assert (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
);

// ==== tests/trojan_memory_host_tb.sv ====
/* Trojan memory host testbench
   Steps a reference model beside the DUT and predicts every scrambled word */

`timescale 1ns/10ps

`include "trojan_params.svh"

module trojan_memory_host_tb;

    localparam int MAX_CYCLES = 2000;
    localparam int DEPTH      = 1 << `TROJAN_ADDR_WIDTH;

    logic                 clk;
    logic                 rst;
    trojan_pkg::mem_req_t req;
    trojan_pkg::mem_rsp_t rsp;

    // Reference model state
    logic [127:0]                  m_key;
    logic [63:0]                   m_lfsr;
    logic [`TROJAN_DATA_WIDTH-1:0] model_mem [DEPTH];
    bit                            written [DEPTH];
    logic                          exp_valid;
    logic [`TROJAN_DATA_WIDTH-1:0] exp_rdata;
    bit                            exp_known;

    integer seed;
    int     errors;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;
    int     cycle_count;

    trojan_memory_host dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Returns the load of the current state and the state after this edge
    function automatic logic [63:0] predict_step(
        input  logic [127:0]         key,
        input  logic [63:0]          lfsr,
        input  trojan_pkg::mem_req_t r,
        output logic [127:0]         key_after,
        output logic [63:0]          lfsr_after
    );
        logic [7:0] low_byte;
        low_byte = key[127:120] ^ r.addr;
        if (r.wr || r.rd) begin
            key_after = {key[119:0], low_byte};
        end else begin
            key_after = key;
        end
        lfsr_after = lfsr >> 1;
        if (lfsr[0]) begin
            lfsr_after = lfsr_after ^ `TROJAN_LFSR_TAPS;
        end
        return lfsr ^ key[127:64] ^ key[63:0];
    endfunction

    // Model follows the DUT edge by edge with the same request
    always @(posedge clk or posedge rst) begin
        logic [63:0]  load;
        logic [127:0] key_after;
        logic [63:0]  lfsr_after;
        if (rst) begin
            m_key     = `TROJAN_KEY_SEED;
            m_lfsr    = `TROJAN_LFSR_SEED;
            exp_valid = 1'b0;
            exp_rdata = '0;
            exp_known = 1'b1;
            for (int i = 0; i < DEPTH; i++) begin
                written[i] = 1'b0;
            end
        end else begin
            load = predict_step(m_key, m_lfsr, req, key_after, lfsr_after);
            if (req.wr) begin
                model_mem[req.addr] = req.wdata ^ load[`TROJAN_DATA_WIDTH-1:0];
                written[req.addr]   = 1'b1;
            end else if (req.rd) begin
                exp_rdata = model_mem[req.addr];
                exp_known = written[req.addr];
            end
            exp_valid = req.wr | req.rd;
            m_key     = key_after;
            m_lfsr    = lfsr_after;
        end
    end

    task automatic check_rsp(
        input trojan_pkg::mem_rsp_t got,
        input trojan_pkg::mem_rsp_t exp,
        input bit                   data_known
    );
        if (got.valid !== exp.valid) begin
            errors++;
            $display("CHECK FAILED at %0t: valid is %b, expected %b",
                     $time, got.valid, exp.valid);
        end
        if (data_known && got.rdata !== exp.rdata) begin
            errors++;
            $display("CHECK FAILED at %0t: read data is %h, expected %h",
                     $time, got.rdata, exp.rdata);
        end
    endtask

    task automatic check_idle(
        input trojan_pkg::mem_rsp_t got,
        input trojan_pkg::mem_rsp_t held,
        input bit                   data_known
    );
        if (got.valid !== 1'b0) begin
            errors++;
            $display("CHECK FAILED at %0t: valid is %b on an idle cycle", $time, got.valid);
        end
        if (data_known && got.rdata !== held.rdata) begin
            errors++;
            $display("CHECK FAILED at %0t: idle read data is %h, expected %h held",
                     $time, got.rdata, held.rdata);
        end
    endtask

    task automatic check_key(
        input trojan_pkg::key_word_u got,
        input logic [127:0]          exp
    );
        if (got.flat !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: key is %h, expected %h", $time, got.flat, exp);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        trojan_pkg::mem_rsp_t exp;
        if (!rst) begin
            exp.valid = exp_valid;
            exp.rdata = exp_rdata;
            if (exp_valid) begin
                check_rsp(rsp, exp, exp_known);
            end else begin
                check_idle(rsp, exp, exp_known);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic drive_req(
        input logic                          wr,
        input logic                          rd,
        input logic [`TROJAN_ADDR_WIDTH-1:0] addr,
        input logic [`TROJAN_DATA_WIDTH-1:0] data
    );
        @(negedge clk);
        req.wr    = wr;
        req.rd    = rd;
        req.addr  = addr;
        req.wdata = data;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_req(1'b0, 1'b0, '0, '0);
        end
    endtask

    task automatic start_test;
        test_errors = errors;
    endtask

    // Lets the last response and one idle cycle get checked first
    task automatic finish_test(input string name);
        idle(2);
        @(posedge clk);
        if (errors == test_errors) begin
            tests_passed++;
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s (%0d errors)", name, errors - test_errors);
        end
    endtask

    initial begin
        logic [31:0] r;
        rst          = 1'b1;
        req          = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed         = 32'h7f86_9331;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        start_test();
        idle(4);
        finish_test("reset state");

        start_test();
        drive_req(1'b1, 1'b0, 8'h2a, 16'($random(seed)));
        drive_req(1'b0, 1'b1, 8'h2a, '0);
        finish_test("write then read");

        // Each write sees a new key and a new LFSR state
        start_test();
        for (int i = 0; i < 16; i++) begin
            drive_req(1'b1, 1'b0, 8'(i * 4 + 1), 16'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            drive_req(1'b0, 1'b1, 8'(i * 4 + 1), '0);
        end
        finish_test("key advance on access");

        start_test();
        for (int i = 0; i < 8; i++) begin
            drive_req(1'b1, 1'b0, 8'(8'h30 + i * 2), 16'($random(seed)));
            for (int j = 0; j < i; j++) begin
                drive_req(1'b0, 1'b0, '0, '0);
                check_key(dut.u_key_schedule.key, m_key);
            end
        end
        for (int i = 0; i < 8; i++) begin
            drive_req(1'b0, 1'b1, 8'(8'h30 + i * 2), '0);
            idle(7 - i);
        end
        finish_test("key holds when idle");

        // Combined strobes write and leave the read data alone
        start_test();
        drive_req(1'b1, 1'b0, 8'h07, 16'hbeef);
        drive_req(1'b0, 1'b1, 8'h07, '0);
        drive_req(1'b1, 1'b1, 8'h08, 16'h1234);
        idle(1);
        drive_req(1'b0, 1'b1, 8'h08, '0);
        finish_test("write priority");

        start_test();
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            drive_req(r[0], r[1], {2'b00, r[13:8]}, r[31:16]);
        end
        finish_test("random mix");

        $display("Summary: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+logic
logic/trojan_pkg.sv
logic/key_schedule.sv
logic/trojan_payload.sv
logic/scrambled_memory.sv
logic/trojan_memory_host.sv
tests/trojan_memory_host_assert.sv
tests/trojan_memory_host_tb.sv

// ==== Makefile ====
# Verilator build and run for the trojan memory host

TOP := trojan_memory_host_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
